// ==== hist_builder.f ====
+incdir+include
rtl/sifh_pkg.sv
rtl/hist_inc_if.sv
rtl/hist_drain_if.sv
rtl/hist_frame_seq.sv
rtl/hist_bin_memory.sv
rtl/hist_readout.sv
rtl/hist_builder.sv
test/hist_builder_tb.sv

// ==== include/sifh_cfg.svh ====
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// time-bin number width, 8 bins
`define SIFH_NB 3

// bin count width, saturates at all ones
`define SIFH_PEAK_MAX 4

// hits that make up one pixel
`define SIFH_DATA_NUM 6

// pixels per acquisition
`define SIFH_PIXEL_NUM 2

// acquisitions summed into one frame
`define SIFH_ACQ_NUM 2

// pixel index width, must cover SIFH_PIXEL_NUM
`define SIFH_PIX_W 1

`endif

// ==== rtl/hist_bin_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_bin_memory (
    input wire logic clk,
    input wire logic res,
    hist_inc_if.mem inc,
    hist_drain_if.mem drain
);

    // one bank holds every pixel and bin
    localparam int ENTRIES = 2 ** $bits(sifh_pkg::entry_t);

    // bank 0 and bank 1
    sifh_pkg::count_t mem [2][ENTRIES];

    logic fill_bank;
    sifh_pkg::entry_t inc_idx;
    sifh_pkg::count_t fill_cur;
    logic fill_sat;

    // fill side is always the bank not being drained
    assign fill_bank = ~inc.drain_bank;

    // pixel-major entry layout
    assign inc_idx = {inc.pixel, inc.bin};

    // current count of the hit bin
    assign fill_cur = mem[fill_bank][inc_idx];
    assign fill_sat = &fill_cur;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // both banks start clear
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < ENTRIES; e++) begin
                    mem[b][e] <= '0;
                end
            end
            drain.data <= '0;
        end else begin
            // saturating increment
            if (inc.inc && !fill_sat) begin
                mem[fill_bank][inc_idx] <= fill_cur + 1'b1;
            end
            // read and clear on the drain side
            if (drain.rd) begin
                drain.data <= mem[inc.drain_bank][drain.index];
                mem[inc.drain_bank][drain.index] <= '0;
            end
        end
    end

    // bank must not swap in the middle of a drain,
    // else later reads would hit the bank being filled
    a_no_swap_in_drain: assert property (
        @(posedge clk) disable iff (!res)
        drain.rd |=> !drain.rd || $stable(inc.drain_bank)
    ) else $error("bank swap while drain in progress");

endmodule

`default_nettype wire

// ==== rtl/hist_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_builder (
    input wire logic clk,
    input wire logic res,
    // photon hit strobe and its time bin
    input wire logic hit,
    input wire sifh_pkg::bin_t hit_bin,
    // frame complete pulse
    output logic frame_done,
    // drained histogram stream
    output logic hist_valid,
    output sifh_pkg::pixel_t hist_pixel,
    output sifh_pkg::bin_t hist_bin,
    output sifh_pkg::count_t hist_count,
    // bank currently drained
    output logic hist_bank
);

    hist_inc_if inc_bus ();
    hist_drain_if drain_bus ();

    // event grouping and bank swap
    hist_frame_seq u_frame_seq (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_bin    (hit_bin),
        .inc        (inc_bus.seq),
        .frame_done (frame_done)
    );

    // double-banked counters
    hist_bin_memory u_bin_memory (
        .clk   (clk),
        .res   (res),
        .inc   (inc_bus.mem),
        .drain (drain_bus.mem)
    );

    // streams out and clears the retired bank
    hist_readout u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .drain      (drain_bus.rdo),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count)
    );

    assign hist_bank = inc_bus.drain_bank;

endmodule

`default_nettype wire

// ==== rtl/hist_drain_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// drain reads between readout and bin memory
interface hist_drain_if;

    // read strobe, entry is also cleared
    logic rd;
    // entry to read from the drain bank
    sifh_pkg::entry_t index;
    // count of the entry, one cycle after rd
    sifh_pkg::count_t data;

    modport rdo (
        output rd, index,
        input data
    );

    modport mem (
        input rd, index,
        output data
    );

endinterface

`default_nettype wire

// ==== rtl/hist_frame_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_cfg.svh"

module hist_frame_seq (
    input wire logic clk,
    input wire logic res,
    input wire logic hit,
    input wire sifh_pkg::bin_t hit_bin,
    hist_inc_if.seq inc,
    output logic frame_done
);

    // counter widths, at least one bit each
    localparam int EV_W  = (`SIFH_DATA_NUM > 1) ? $clog2(`SIFH_DATA_NUM) : 1;
    localparam int ACQ_W = (`SIFH_ACQ_NUM > 1) ? $clog2(`SIFH_ACQ_NUM) : 1;

    logic [EV_W-1:0] ev_cnt;
    sifh_pkg::pixel_t pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic drain_bank;

    logic last_ev;
    logic last_pix;
    logic last_acq;

    // wrap points of the three counters
    assign last_ev  = ev_cnt == EV_W'(`SIFH_DATA_NUM - 1);
    assign last_pix = pix_cnt == sifh_pkg::pixel_t'(`SIFH_PIXEL_NUM - 1);
    assign last_acq = acq_cnt == ACQ_W'(`SIFH_ACQ_NUM - 1);

    // hits go straight through, written at the same edge
    assign inc.inc        = hit;
    assign inc.bin        = hit_bin;
    assign inc.pixel      = pix_cnt;
    assign inc.drain_bank = drain_bank;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ev_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            drain_bank <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // single pulse per frame
            frame_done <= 1'b0;
            if (hit) begin
                if (!last_ev) begin
                    ev_cnt <= ev_cnt + 1'b1;
                end else begin
                    // pixel full, move to next one
                    ev_cnt <= '0;
                    if (!last_pix) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        if (!last_acq) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // frame complete, swap banks
                            acq_cnt    <= '0;
                            drain_bank <= ~drain_bank;
                            frame_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // an unknown bin would corrupt an arbitrary entry
    a_hit_bin_known: assert property (
        @(posedge clk) disable iff (!res)
        hit |-> !$isunknown(hit_bin)
    ) else $error("hit with unknown bin number");

endmodule

`default_nettype wire

// ==== rtl/hist_inc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// increment requests, frame sequencer to bin memory
interface hist_inc_if;

    // one-cycle strobe, one count per cycle
    logic inc;
    // target bin of the hit
    sifh_pkg::bin_t bin;
    // pixel the hit belongs to
    sifh_pkg::pixel_t pixel;
    // bank being drained, the other one fills
    logic drain_bank;

    modport seq (
        output inc, bin, pixel, drain_bank
    );

    modport mem (
        input inc, bin, pixel, drain_bank
    );

endinterface

`default_nettype wire

// ==== rtl/hist_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_readout (
    input wire logic clk,
    input wire logic res,
    input wire logic frame_done,
    hist_drain_if.rdo drain,
    output logic hist_valid,
    output sifh_pkg::pixel_t hist_pixel,
    output sifh_pkg::bin_t hist_bin,
    output sifh_pkg::count_t hist_count
);

    sifh_pkg::drain_state_t state;
    sifh_pkg::entry_t rd_idx;
    logic rd_en;

    // read stage, lines up with returned data
    logic pipe_vld;
    sifh_pkg::entry_t pipe_idx;

    // one read per cycle while draining
    assign rd_en       = state == sifh_pkg::DRAIN;
    assign drain.rd    = rd_en;
    assign drain.index = rd_idx;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state  <= sifh_pkg::IDLE;
            rd_idx <= '0;
        end else begin
            case (state)
                sifh_pkg::IDLE: begin
                    if (frame_done) begin
                        state  <= sifh_pkg::DRAIN;
                        rd_idx <= '0;
                    end
                end
                sifh_pkg::DRAIN: begin
                    rd_idx <= rd_idx + 1'b1;
                    // last entry issued
                    if (&rd_idx) begin
                        state <= sifh_pkg::IDLE;
                    end
                end
                default: state <= sifh_pkg::IDLE;
            endcase
        end
    end

    // valid flags follow the read by two edges
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pipe_vld   <= 1'b0;
            hist_valid <= 1'b0;
        end else begin
            pipe_vld   <= rd_en;
            hist_valid <= pipe_vld;
        end
    end

    // entry index travels next to the count
    always_ff @(posedge clk) begin
        pipe_idx <= rd_idx;
        {hist_pixel, hist_bin} <= pipe_idx;
        hist_count <= drain.data;
    end

    // next frame must not complete before the drain ends
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!res)
        frame_done |-> state == sifh_pkg::IDLE
    ) else $error("frame done while previous drain still running");

endmodule

`default_nettype wire

// ==== rtl/sifh_pkg.sv ====
`default_nettype none

`include "sifh_cfg.svh"

package sifh_pkg;

    // time-bin number as delivered with each hit
    typedef logic [`SIFH_NB-1:0] bin_t;

    // hit count of one bin
    typedef logic [`SIFH_PEAK_MAX-1:0] count_t;

    // pixel index inside an acquisition
    typedef logic [`SIFH_PIX_W-1:0] pixel_t;

    // bank entry, pixel in the upper bits then bin
    typedef logic [`SIFH_PIX_W+`SIFH_NB-1:0] entry_t;

    // readout sequencer states
    typedef enum logic {
        IDLE,
        DRAIN
    } drain_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the hist_builder testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f hist_builder.f --top-module hist_builder_tb \
    -o sim_hist_builder
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_hist_builder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== test/hist_builder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_cfg.svh"

module hist_builder_tb;

    localparam int NBINS      = 1 << `SIFH_NB;
    localparam int NPIX       = 1 << `SIFH_PIX_W;
    localparam int ENTRIES    = NPIX * NBINS;
    localparam int CNT_MAX    = (1 << `SIFH_PEAK_MAX) - 1;
    localparam int FRAME_HITS = `SIFH_DATA_NUM * `SIFH_PIXEL_NUM * `SIFH_ACQ_NUM;
    localparam int FRAMES     = 8;
    localparam int TIMEOUT    = 400;
    localparam int SEED       = 68911;

    logic clk;
    logic res;
    logic hit;
    sifh_pkg::bin_t hit_bin;
    logic frame_done;
    logic hist_valid;
    sifh_pkg::pixel_t hist_pixel;
    sifh_pkg::bin_t hist_bin;
    sifh_pkg::count_t hist_count;
    logic hist_bank;

    // reference histogram of the frame being filled
    int model_cnt [NPIX][NBINS];
    int model_ev;
    int model_pix;
    int model_acq;
    int model_frames;
    // finished frames as pixel-major counts
    int exp_q [$];
    // frame end flags for the driven cycle and the one before
    logic done_now;
    logic done_prev;

    int val_errors;
    int other_errors;
    logic aborted;

    hist_builder uut (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_bin    (hit_bin),
        .frame_done (frame_done),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .hist_bank  (hist_bank)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_count(input sifh_pkg::count_t exp, input sifh_pkg::count_t act);
        if (act !== exp) begin
            $display("Fail hist_count: expected %h, got %h", exp, act);
            val_errors++;
        end
    endtask

    task automatic check_entry(input sifh_pkg::pixel_t exp_pix, input sifh_pkg::bin_t exp_bin,
                               input sifh_pkg::pixel_t act_pix, input sifh_pkg::bin_t act_bin);
        if (act_pix !== exp_pix) begin
            $display("Fail hist_pixel: expected %h, got %h", exp_pix, act_pix);
            val_errors++;
        end
        if (act_bin !== exp_bin) begin
            $display("Fail hist_bin: expected %h, got %h", exp_bin, act_bin);
            val_errors++;
        end
    endtask

    task automatic check_bank(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail hist_bank: expected %h, got %h", exp, act);
            val_errors++;
        end
    endtask

    // single-bit strobes like frame_done and hist_valid
    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, got %h", name, exp, act);
            val_errors++;
        end
    endtask

    task automatic clear_model();
        for (int p = 0; p < NPIX; p++) begin
            for (int b = 0; b < NBINS; b++) begin
                model_cnt[p][b] = 0;
            end
        end
    endtask

    // hand the frame over to the drain checker
    task automatic close_frame();
        for (int p = 0; p < NPIX; p++) begin
            for (int b = 0; b < NBINS; b++) begin
                exp_q.push_back(model_cnt[p][b]);
            end
        end
        clear_model();
        model_frames++;
        done_now = 1'b1;
    endtask

    // saturating count of one hit and the event, pixel and acquisition grouping
    task automatic model_hit(input sifh_pkg::bin_t b);
        if (model_cnt[model_pix][b] < CNT_MAX) begin
            model_cnt[model_pix][b]++;
        end
        model_ev++;
        if (model_ev == `SIFH_DATA_NUM) begin
            model_ev = 0;
            model_pix++;
            if (model_pix == `SIFH_PIXEL_NUM) begin
                model_pix = 0;
                model_acq++;
                if (model_acq == `SIFH_ACQ_NUM) begin
                    model_acq = 0;
                    close_frame();
                end
            end
        end
    endtask

    // random hits at about 60 % density with bursts biased to one bin
    task automatic drive_hits();
        int guard;
        int burst_left;
        sifh_pkg::bin_t burst_bin;
        sifh_pkg::bin_t b;
        logic h;
        guard = 0;
        burst_left = 0;
        burst_bin = '0;
        while (model_frames < FRAMES && guard < FRAMES * FRAME_HITS * 20) begin
            @(posedge clk);
            guard++;
            done_prev = done_now;
            done_now = 1'b0;
            h = ($urandom % 100) < 60;
            if (burst_left == 0 && ($urandom % 10) == 0) begin
                burst_left = 10 + ($urandom % 10);
                burst_bin = sifh_pkg::bin_t'($urandom);
            end
            if (burst_left > 0) begin
                b = burst_bin;
                if (h) begin
                    burst_left--;
                end
            end else begin
                b = sifh_pkg::bin_t'($urandom);
            end
            hit <= h;
            hit_bin <= b;
            if (h) begin
                model_hit(b);
            end
        end
        if (model_frames < FRAMES) begin
            $display("stimulus gave up before all frames were complete");
            other_errors++;
        end
        // idle cycles let the last frame end flag shift through
        repeat (2) begin
            @(posedge clk);
            done_prev = done_now;
            done_now = 1'b0;
            hit <= 1'b0;
        end
    endtask

    // frame_done must follow the frame's last hit by one edge
    always @(negedge clk) begin
        if (res) begin
            check_flag("frame_done", done_prev, frame_done);
        end
    end

    // each frame_done starts 16 consecutive entries three cycles later
    task automatic check_drains();
        int t;
        sifh_pkg::count_t exp_c;
        @(negedge clk);
        for (int f = 0; f < FRAMES && !aborted; f++) begin
            t = 0;
            while (!frame_done && !aborted) begin
                if (hist_valid) begin
                    $display("hist_valid went high outside a drain");
                    other_errors++;
                end
                @(negedge clk);
                t++;
                if (t > TIMEOUT) begin
                    $display("timed out waiting for frame_done of frame %0d", f);
                    other_errors++;
                    aborted = 1'b1;
                end
            end
            if (!aborted && exp_q.size() < ENTRIES) begin
                $display("frame_done came with no finished frame in the model");
                other_errors++;
                aborted = 1'b1;
            end
            if (!aborted) begin
                // first drain uses bank 1 and later ones alternate
                check_bank((f % 2) == 0, hist_bank);
                t = 0;
                do begin
                    @(negedge clk);
                    t++;
                end while (!hist_valid && t <= TIMEOUT);
                if (!hist_valid) begin
                    $display("timed out waiting for hist_valid of frame %0d", f);
                    other_errors++;
                    aborted = 1'b1;
                end else if (t != 3) begin
                    $display("drain began %0d cycles after frame_done instead of 3", t);
                    other_errors++;
                end
            end
            if (!aborted) begin
                for (int k = 0; k < ENTRIES; k++) begin
                    if (k > 0) begin
                        @(negedge clk);
                    end
                    exp_c = sifh_pkg::count_t'(exp_q.pop_front());
                    check_flag("hist_valid", 1'b1, hist_valid);
                    check_entry(sifh_pkg::pixel_t'(k / NBINS), sifh_pkg::bin_t'(k % NBINS),
                                hist_pixel, hist_bin);
                    check_count(exp_c, hist_count);
                end
                @(negedge clk);
                check_flag("hist_valid", 1'b0, hist_valid);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        res = 1'b0;
        hit = 1'b0;
        hit_bin = '0;
        val_errors = 0;
        other_errors = 0;
        aborted = 1'b0;
        model_ev = 0;
        model_pix = 0;
        model_acq = 0;
        model_frames = 0;
        done_now = 1'b0;
        done_prev = 1'b0;
        clear_model();
        repeat (8) @(posedge clk);
        res <= 1'b1;
        fork
            drive_hits();
            check_drains();
        join
        $display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
